// ==== verilog/cache_pkg.sv ====
package cache_pkg;

	localparam int addr_w         = 12;
	localparam int word_w         = 32;
	localparam int tag_w          = 5;
	localparam int index_w        = 3;
	localparam int offset_w       = 2;
	localparam int byte_w         = 2;
	localparam int num_lines      = 8;
	localparam int words_per_line = 4;
	localparam int mem_addr_w     = tag_w + index_w + offset_w;
	localparam int mem_words      = 1024;
	localparam int stat_w         = 32;

	// byte address as the processor sees it, msb first
	typedef struct packed {
		logic [tag_w-1:0]    tag;
		logic [index_w-1:0]  index;
		logic [offset_w-1:0] offset;
		logic [byte_w-1:0]   byte_off;
	} cache_addr_t;

	typedef struct packed {
		logic              write;
		cache_addr_t       addr;
		logic [word_w-1:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic [word_w-1:0] rdata;
		logic              was_hit;
	} cpu_rsp_t;

	// word-wide command to the backing memory
	typedef struct packed {
		logic                  we;
		logic [mem_addr_w-1:0] addr;
		logic [word_w-1:0]     wdata;
	} mem_req_t;

	typedef struct packed {
		logic             valid;
		logic [tag_w-1:0] tag;
	} line_meta_t;

	typedef enum logic [2:0] {
		idle,
		lookup,
		refill,
		refill_wait,
		write_through,
		respond
	} ctrl_state_t;

	typedef enum logic [2:0] {
		none,
		read_hit,
		read_miss,
		write_hit,
		write_miss
	} stat_event_t;

endpackage

// ==== verilog/cache_ctrl_fsm.sv ====
`timescale 1ns/1ns

module cache_ctrl_fsm
	import cache_pkg::*;
(
	input  logic                CLK,
	input  logic                rst,
	input  logic                req_valid,
	input  cpu_req_t            req,
	input  logic                rsp_ready,
	input  logic                hit,
	input  logic [word_w-1:0]   rd_word,
	input  logic [word_w-1:0]   mem_rdata,
	input  logic [offset_w-1:0] beat,
	input  logic                last,
	output logic                req_ready,
	output logic                rsp_valid,
	output cpu_rsp_t            rsp,
	output logic                mem_valid,
	output mem_req_t            mem_req,
	output logic [index_w-1:0]  index,
	output logic [tag_w-1:0]    tag,
	output logic                fill_en,
	output logic [offset_w-1:0] fill_word,
	output logic [word_w-1:0]   fill_data,
	output logic                word_we,
	output logic [offset_w-1:0] word_sel,
	output logic [word_w-1:0]   word_data,
	output logic                set_valid,
	output logic                clear_valid,
	output logic                cnt_start,
	output logic                cnt_step,
	output stat_event_t         stat_ev
);

	ctrl_state_t state, state_nxt;
	cpu_req_t    req_q;
	logic        hit_q;

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= idle;
		end else begin
			state <= state_nxt;
		end
	end

	// request and lookup result are held for the whole transaction
	always_ff @(posedge CLK) begin
		if (req_valid && req_ready) begin
			req_q <= req;
		end
		if (state == lookup) begin
			hit_q <= hit;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			idle: begin
				if (req_valid) state_nxt = lookup;
			end
			lookup: begin
				if (!hit) state_nxt = refill;
				else if (req_q.write) state_nxt = write_through;
				else state_nxt = respond;
			end
			refill: state_nxt = refill_wait;
			refill_wait: begin
				// a write miss finishes as a write hit once the line is in
				if (last) state_nxt = req_q.write ? write_through : respond;
				else state_nxt = refill;
			end
			write_through: state_nxt = respond;
			respond: begin
				if (rsp_ready) state_nxt = idle;
			end
			default: state_nxt = idle;
		endcase
	end

	assign req_ready = (state == idle);
	assign rsp_valid = (state == respond);
	assign rsp.rdata = req_q.write ? req_q.wdata : rd_word;
	assign rsp.was_hit = hit_q;

	assign index = req_q.addr.index;
	assign tag = req_q.addr.tag;

	// refill beats read, write-through writes the requested word
	assign mem_valid = (state == refill) || (state == write_through);
	assign mem_req.we = (state == write_through);
	assign mem_req.addr = {req_q.addr.tag, req_q.addr.index,
		(state == write_through) ? req_q.addr.offset : beat};
	assign mem_req.wdata = req_q.wdata;

	assign fill_en = (state == refill_wait);
	assign fill_word = beat;
	assign fill_data = mem_rdata;
	assign set_valid = (state == refill_wait) && last;
	assign clear_valid = (state == refill) && (beat == '0);

	assign word_we = (state == write_through);
	assign word_sel = req_q.addr.offset;
	assign word_data = req_q.wdata;

	assign cnt_start = (state == lookup) && !hit;
	assign cnt_step = (state == refill_wait);

	always_comb begin
		stat_ev = none;
		if (state == lookup) begin
			if (req_q.write) stat_ev = hit ? write_hit : write_miss;
			else stat_ev = hit ? read_hit : read_miss;
		end
	end

endmodule

// ==== verilog/beat_counter.sv ====
`timescale 1ns/1ns

module beat_counter
	import cache_pkg::*;
(
	input  logic                CLK,
	input  logic                rst,
	input  logic                start,
	input  logic                step,
	output logic [offset_w-1:0] beat,
	output logic                last
);

	logic [offset_w-1:0] count;

	// one step per refill beat, after the memory latency cycle
	always_ff @(posedge CLK) begin
		if (rst) begin
			count <= '0;
		end else if (start) begin
			count <= '0;
		end else if (step) begin
			count <= count + 1'b1;
		end
	end

	assign beat = count;
	assign last = (count == offset_w'(words_per_line - 1));

endmodule

// ==== verilog/cache_array.sv ====
`timescale 1ns/1ns

module cache_array
	import cache_pkg::*;
(
	input  logic                CLK,
	input  logic                rst,
	input  logic [index_w-1:0]  index,
	input  logic [tag_w-1:0]    tag,
	input  logic                fill_en,
	input  logic [offset_w-1:0] fill_word,
	input  logic [word_w-1:0]   fill_data,
	input  logic                word_we,
	input  logic [offset_w-1:0] word_sel,
	input  logic [word_w-1:0]   word_data,
	input  logic                set_valid,
	input  logic                clear_valid,
	output logic                hit,
	output logic [word_w-1:0]   rd_word
);

	line_meta_t        meta [num_lines];
	logic [word_w-1:0] data [num_lines][words_per_line];
	line_meta_t        cur_meta;

	// only the valid bits come out of reset
	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < num_lines; i++) begin
				meta[i].valid <= 1'b0;
			end
		end else if (set_valid) begin
			meta[index].valid <= 1'b1;
			meta[index].tag <= tag;
		end else if (clear_valid) begin
			meta[index].valid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (fill_en) begin
			data[index][fill_word] <= fill_data;
		end else if (word_we) begin
			data[index][word_sel] <= word_data;
		end
	end

	assign cur_meta = meta[index];
	assign hit = cur_meta.valid && (cur_meta.tag == tag);
	assign rd_word = data[index][word_sel];

endmodule

// ==== verilog/data_mem.sv ====
`timescale 1ns/1ns

module data_mem
	import cache_pkg::*;
(
	input  logic              CLK,
	input  logic              mem_valid,
	input  mem_req_t          mem_req,
	output logic [word_w-1:0] mem_rdata
);

	logic [word_w-1:0] mem [mem_words];

	// read data shows up the cycle after the request
	always_ff @(posedge CLK) begin
		if (mem_valid) begin
			if (mem_req.we) begin
				mem[mem_req.addr] <= mem_req.wdata;
			end else begin
				mem_rdata <= mem[mem_req.addr];
			end
		end
	end

endmodule

// ==== verilog/cache_stats.sv ====
`timescale 1ns/1ns

module cache_stats
	import cache_pkg::*;
(
	input  logic              CLK,
	input  logic              rst,
	input  stat_event_t       stat_ev,
	output logic [stat_w-1:0] rd_hits,
	output logic [stat_w-1:0] rd_misses,
	output logic [stat_w-1:0] wr_hits,
	output logic [stat_w-1:0] wr_misses
);

	always_ff @(posedge CLK) begin
		if (rst) begin
			rd_hits <= '0;
			rd_misses <= '0;
			wr_hits <= '0;
			wr_misses <= '0;
		end else begin
			case (stat_ev)
				read_hit: rd_hits <= rd_hits + 1'b1;
				read_miss: rd_misses <= rd_misses + 1'b1;
				write_hit: wr_hits <= wr_hits + 1'b1;
				write_miss: wr_misses <= wr_misses + 1'b1;
				default: ;
			endcase
		end
	end

endmodule

// ==== verilog/cache_top.sv ====
`timescale 1ns/1ns

module cache_top
	import cache_pkg::*;
(
	input  logic              CLK,
	input  logic              rst,
	input  logic              req_valid,
	input  cpu_req_t          req,
	input  logic              rsp_ready,
	output logic              req_ready,
	output logic              rsp_valid,
	output cpu_rsp_t          rsp,
	output logic [stat_w-1:0] rd_hits,
	output logic [stat_w-1:0] rd_misses,
	output logic [stat_w-1:0] wr_hits,
	output logic [stat_w-1:0] wr_misses
);

	logic                hit;
	logic [word_w-1:0]   rd_word;
	logic [word_w-1:0]   mem_rdata;
	logic [offset_w-1:0] beat;
	logic                last;
	logic                mem_valid;
	mem_req_t            mem_req;
	logic [index_w-1:0]  index;
	logic [tag_w-1:0]    tag;
	logic                fill_en;
	logic [offset_w-1:0] fill_word;
	logic [word_w-1:0]   fill_data;
	logic                word_we;
	logic [offset_w-1:0] word_sel;
	logic [word_w-1:0]   word_data;
	logic                set_valid;
	logic                clear_valid;
	logic                cnt_start;
	logic                cnt_step;
	stat_event_t         stat_ev;

	cache_ctrl_fsm u_ctrl (
		.CLK         (CLK),
		.rst         (rst),
		.req_valid   (req_valid),
		.req         (req),
		.rsp_ready   (rsp_ready),
		.hit         (hit),
		.rd_word     (rd_word),
		.mem_rdata   (mem_rdata),
		.beat        (beat),
		.last        (last),
		.req_ready   (req_ready),
		.rsp_valid   (rsp_valid),
		.rsp         (rsp),
		.mem_valid   (mem_valid),
		.mem_req     (mem_req),
		.index       (index),
		.tag         (tag),
		.fill_en     (fill_en),
		.fill_word   (fill_word),
		.fill_data   (fill_data),
		.word_we     (word_we),
		.word_sel    (word_sel),
		.word_data   (word_data),
		.set_valid   (set_valid),
		.clear_valid (clear_valid),
		.cnt_start   (cnt_start),
		.cnt_step    (cnt_step),
		.stat_ev     (stat_ev)
	);

	beat_counter u_beats (
		.CLK   (CLK),
		.rst   (rst),
		.start (cnt_start),
		.step  (cnt_step),
		.beat  (beat),
		.last  (last)
	);

	cache_array u_array (
		.CLK         (CLK),
		.rst         (rst),
		.index       (index),
		.tag         (tag),
		.fill_en     (fill_en),
		.fill_word   (fill_word),
		.fill_data   (fill_data),
		.word_we     (word_we),
		.word_sel    (word_sel),
		.word_data   (word_data),
		.set_valid   (set_valid),
		.clear_valid (clear_valid),
		.hit         (hit),
		.rd_word     (rd_word)
	);

	data_mem u_mem (
		.CLK       (CLK),
		.mem_valid (mem_valid),
		.mem_req   (mem_req),
		.mem_rdata (mem_rdata)
	);

	cache_stats u_stats (
		.CLK       (CLK),
		.rst       (rst),
		.stat_ev   (stat_ev),
		.rd_hits   (rd_hits),
		.rd_misses (rd_misses),
		.wr_hits   (wr_hits),
		.wr_misses (wr_misses)
	);

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
	output logic CLK,
	output logic rst
);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// reset held over the first ten rising edges
	initial begin
		rst = 1'b1;
		repeat (10) @(posedge CLK);
		#1;
		rst = 1'b0;
	end

endmodule

// ==== verification/tb_cache.sv ====
`timescale 1ns/1ns

module tb_cache
	import cache_pkg::*;
();

	localparam int num_reqs = 222;
	localparam int timeout_ns = (num_reqs * 11 * 4 + 100) * 10;

	logic              CLK;
	logic              rst;
	logic              req_valid;
	cpu_req_t          req;
	logic              rsp_ready;
	logic              req_ready;
	logic              rsp_valid;
	cpu_rsp_t          rsp;
	logic [stat_w-1:0] rd_hits;
	logic [stat_w-1:0] rd_misses;
	logic [stat_w-1:0] wr_hits;
	logic [stat_w-1:0] wr_misses;

	// reference model state
	logic [word_w-1:0] shadow_mem [mem_words];
	bit                known [mem_words];
	logic [tag_w-1:0]  model_tag [num_lines];
	bit                model_valid [num_lines];
	int                exp_rd_hits;
	int                exp_rd_misses;
	int                exp_wr_hits;
	int                exp_wr_misses;
	cpu_rsp_t          exp_rsp;
	int                exp_lat;
	int                lat;
	int                errors;
	int                tests_run;
	int                tests_failed;
	int                test_base;

	tb_clock u_clk (
		.CLK (CLK),
		.rst (rst)
	);

	cache_top uut (
		.CLK       (CLK),
		.rst       (rst),
		.req_valid (req_valid),
		.req       (req),
		.rsp_ready (rsp_ready),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.rsp       (rsp),
		.rd_hits   (rd_hits),
		.rd_misses (rd_misses),
		.wr_hits   (wr_hits),
		.wr_misses (wr_misses)
	);

	// edges since the accept edge
	always @(posedge CLK) begin
		if (req_valid && req_ready) lat <= 1;
		else lat <= lat + 1;
	end

	a_latency: assert property (@(posedge CLK) disable iff (rst)
		$rose(rsp_valid) |-> lat == exp_lat)
	else begin
		$display("Error at %0t: response latency wrong, expected %0d cycles", $time, exp_lat);
		errors++;
	end

	a_rdata: assert property (@(posedge CLK) disable iff (rst)
		rsp_valid && rsp_ready |-> rsp.rdata == exp_rsp.rdata)
	else begin
		$display("Error at %0t: rdata %h, expected %h", $time, rsp.rdata, exp_rsp.rdata);
		errors++;
	end

	a_was_hit: assert property (@(posedge CLK) disable iff (rst)
		rsp_valid && rsp_ready |-> rsp.was_hit == exp_rsp.was_hit)
	else begin
		$display("Error at %0t: was_hit %b, expected %b", $time, rsp.was_hit,
			exp_rsp.was_hit);
		errors++;
	end

	a_rsp_stable: assert property (@(posedge CLK) disable iff (rst)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
	else begin
		$display("Error at %0t: response changed while stalled", $time);
		errors++;
	end

	a_no_accept: assert property (@(posedge CLK) disable iff (rst)
		rsp_valid |-> !req_ready)
	else begin
		$display("Error at %0t: req_ready high during a pending response", $time);
		errors++;
	end

	function automatic cache_addr_t make_addr(input logic [tag_w-1:0] tag,
			input logic [index_w-1:0] index, input logic [offset_w-1:0] offset);
		cache_addr_t a;
		a.tag = tag;
		a.index = index;
		a.offset = offset;
		a.byte_off = '0;
		return a;
	endfunction

	// direct mapped, write allocate, refill on any miss
	task automatic predict(input logic write, input cache_addr_t addr,
			input logic [word_w-1:0] wdata);
		logic [mem_addr_w-1:0] wa;
		bit                    hit;
		wa = {addr.tag, addr.index, addr.offset};
		hit = model_valid[addr.index] && (model_tag[addr.index] == addr.tag);
		if (!hit) begin
			model_valid[addr.index] = 1'b1;
			model_tag[addr.index] = addr.tag;
		end
		if (write) begin
			shadow_mem[wa] = wdata;
			known[wa] = 1'b1;
			exp_rsp.rdata = wdata;
			if (hit) exp_wr_hits++;
			else exp_wr_misses++;
		end else begin
			exp_rsp.rdata = shadow_mem[wa];
			if (hit) exp_rd_hits++;
			else exp_rd_misses++;
		end
		exp_rsp.was_hit = hit;
		// a refill adds four beats of two cycles
		exp_lat = (write ? 3 : 2) + (hit ? 0 : 8);
	endtask

	task automatic access(input logic write, input cache_addr_t addr,
			input logic [word_w-1:0] wdata, input int hold);
		predict(write, addr, wdata);
		req.write = write;
		req.addr = addr;
		req.wdata = wdata;
		req_valid = 1'b1;
		rsp_ready = (hold == 0);
		while (!req_ready) begin
			@(posedge CLK);
			#1;
		end
		@(posedge CLK);
		#1;
		req_valid = 1'b0;
		while (!rsp_valid) begin
			@(posedge CLK);
			#1;
		end
		repeat (hold) begin
			@(posedge CLK);
			#1;
		end
		rsp_ready = 1'b1;
		@(posedge CLK);
		#1;
	endtask

	task automatic start_test();
		test_base = errors;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != test_base) tests_failed++;
		$display("%s: %s", name, (errors == test_base) ? "ok" : "failed");
	endtask

	initial begin
		cache_addr_t a;
		bit          wr;
		void'($urandom(14712));
		req_valid = 1'b0;
		req = '0;
		rsp_ready = 1'b1;
		errors = 0;
		@(negedge rst);

		start_test();
		assert (req_ready && !rsp_valid) else begin
			$display("Error at %0t: handshake outputs wrong after reset", $time);
			errors++;
		end
		assert (rd_hits == 0 && rd_misses == 0 && wr_hits == 0 && wr_misses == 0) else begin
			$display("Error at %0t: counters not zero after reset", $time);
			errors++;
		end
		finish_test("reset state");

		start_test();
		a = make_addr(5'd3, 3'd5, 2'd2);
		access(1'b1, a, $urandom(), 0);
		access(1'b0, a, '0, 0);
		finish_test("write miss then read hit");

		start_test();
		for (int w = 0; w < words_per_line; w++) begin
			access(1'b1, make_addr(5'd1, 3'd2, w[1:0]), $urandom(), 0);
		end
		access(1'b1, make_addr(5'd9, 3'd2, 2'd0), $urandom(), 0);
		for (int w = 0; w < words_per_line; w++) begin
			access(1'b0, make_addr(5'd1, 3'd2, w[1:0]), '0, 0);
		end
		finish_test("read miss refill");

		start_test();
		access(1'b1, make_addr(5'd1, 3'd2, 2'd1), $urandom(), 0);
		access(1'b1, make_addr(5'd9, 3'd2, 2'd3), $urandom(), 0);
		access(1'b0, make_addr(5'd1, 3'd2, 2'd1), '0, 0);
		finish_test("write through");

		start_test();
		for (int i = 0; i < 8; i++) begin
			access(i[0], make_addr(5'd1, 3'd2, i[1:0]), $urandom(), $urandom_range(7, 0));
		end
		finish_test("back-pressure");

		start_test();
		for (int i = 0; i < 200; i++) begin
			a = make_addr(5'($urandom_range(3, 0)), 3'($urandom_range(7, 0)),
				2'($urandom_range(3, 0)));
			// unwritten words get written first
			wr = !known[{a.tag, a.index, a.offset}] || ($urandom_range(1, 0) == 1);
			access(wr, a, $urandom(), 0);
		end
		assert (rd_hits == exp_rd_hits && rd_misses == exp_rd_misses &&
				wr_hits == exp_wr_hits && wr_misses == exp_wr_misses) else begin
			$display("Error at %0t: counters %0d/%0d/%0d/%0d, expected %0d/%0d/%0d/%0d",
				$time, rd_hits, rd_misses, wr_hits, wr_misses,
				exp_rd_hits, exp_rd_misses, exp_wr_hits, exp_wr_misses);
			errors++;
		end
		finish_test("random mix");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#(timeout_ns);
		$display("run timed out after %0d ns, a request never completed", timeout_ns);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== tb.f ====
verilog/cache_pkg.sv
verilog/cache_ctrl_fsm.sv
verilog/beat_counter.sv
verilog/cache_array.sv
verilog/data_mem.sv
verilog/cache_stats.sv
verilog/cache_top.sv
verification/tb_clock.sv
verification/tb_cache.sv

// ==== Makefile ====
TOP := tb_cache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
